/* common/if_pkg.sv */
package if_pkg;

  // ------------------------------
  // widths that carry a meaning
  // ------------------------------

  // byte address of an instruction word
  typedef logic [31:0] addr_t;

  // raw 32-bit instruction, no compressed forms
  typedef logic [31:0] instr_t;

  // upper address bits of the machine trap vector
  typedef logic [23:0] trap_base_t;

  // interrupt line number used by vectored mode
  typedef logic [4:0] exc_vec_t;

  // boot address without bit 0
  typedef logic [30:0] boot_addr_t;

  // ------------------------------
  // redirect encodings
  // ------------------------------

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_FENCEI    = 3'b001,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101,
    PC_DRET      = 3'b111
  } pc_mux_e;

  // kind of exception target when PC_EXCEPTION is chosen
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'b00,
    EXC_PC_IRQ       = 2'b01,
    EXC_PC_DBD       = 2'b10
  } exc_pc_mux_e;

  // which target the redirect takes
  typedef struct packed {
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_pc_mux;
    exc_vec_t    exc_vec;
  } redirect_t;

  // candidate addresses offered by the rest of the core
  typedef struct packed {
    boot_addr_t boot_addr;
    trap_base_t trap_base;
    addr_t      jump_target_id;
    addr_t      jump_target_ex;
    addr_t      mepc;
    addr_t      depc;
  } pc_sources_t;

  // IF/ID register as seen by decode
  typedef struct packed {
    logic   valid;
    instr_t instr;
    addr_t  pc;
  } if_id_t;

  // fetch controller states
  typedef enum logic [2:0] {
    FS_IDLE,
    FS_REQ,
    FS_WAIT,
    FS_FLUSH,
    FS_FULL
  } fetch_state_e;

endpackage

/* fetch/fetch_pc_counter.sv */
`timescale 1ns/1ps

module fetch_pc_counter #(
  parameter if_pkg::addr_t DM_HALT_ADDR = 32'h1A11_0800
) (
  input  logic                clk,
  input  logic                rst_n,

  // strobes from the controller
  input  logic                load_i,
  input  logic                advance_i,

  // target choice and candidates
  input  if_pkg::redirect_t   redirect_i,
  input  if_pkg::pc_sources_t sources_i,

  // PC of the instruction in decode, for fence.i
  input  if_pkg::addr_t       pc_id_i,

  output if_pkg::addr_t       pc_o
);

  if_pkg::addr_t exc_pc;
  if_pkg::addr_t target;
  if_pkg::addr_t pc_q;

  // ------------------------------
  // exception target
  // ------------------------------
  always_comb begin
    exc_pc = '0;
    case (redirect_i.exc_pc_mux)
      // all synchronous traps share the base
      if_pkg::EXC_PC_EXCEPTION: exc_pc = {sources_i.trap_base, 8'h00};
      // vectored irq, 4 bytes per line
      if_pkg::EXC_PC_IRQ: begin
        exc_pc = {sources_i.trap_base, 1'b0, redirect_i.exc_vec, 2'b00};
      end
      // debug halt goes into the debug module ROM
      if_pkg::EXC_PC_DBD:       exc_pc = DM_HALT_ADDR;
      default:                  exc_pc = '0;
    endcase
  end

  // ------------------------------
  // redirect target
  // ------------------------------
  always_comb begin
    target = '0;
    case (redirect_i.pc_mux)
      if_pkg::PC_BOOT:      target = {sources_i.boot_addr, 1'b0};
      if_pkg::PC_JUMP:      target = sources_i.jump_target_id;
      if_pkg::PC_BRANCH:    target = sources_i.jump_target_ex;
      if_pkg::PC_EXCEPTION: target = exc_pc;
      // return from trap or from debug
      if_pkg::PC_MRET:      target = sources_i.mepc;
      if_pkg::PC_DRET:      target = sources_i.depc;
      // refetch everything after the fence.i
      if_pkg::PC_FENCEI:    target = pc_id_i + 32'd4;
      default:              target = '0;
    endcase
  end

  // ------------------------------
  // PC register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (load_i) begin
      // halfword alignment forced on every redirect
      pc_q <= {target[31:1], 1'b0};
    end else if (advance_i) begin
      // next sequential word
      pc_q <= pc_q + 32'd4;
    end
  end

  assign pc_o = pc_q;

endmodule

/* fetch/fetch_ctrl_fsm.sv */
`timescale 1ns/1ps

module fetch_ctrl_fsm (
  input  logic clk,
  input  logic rst_n,

  // start and redirect
  input  logic req_i,
  input  logic pc_set_i,

  // memory handshake
  input  logic instr_gnt_i,
  input  logic instr_rvalid_i,

  // back-pressure from decode
  input  logic halt_if_i,
  input  logic id_slot_free_i,

  // memory request
  output logic instr_req_o,

  // single-cycle strobes to the counter and the pipe
  output logic load_pc_o,
  output logic advance_pc_o,
  output logic capture_o,
  output logic transfer_o,

  output logic if_busy_o
);

  if_pkg::fetch_state_e state_q;
  if_pkg::fetch_state_e state_d;

  // a response is still due from memory after this edge
  logic rsp_owed;

  // ------------------------------
  // state register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= if_pkg::FS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // granted right now, or waiting and rvalid not here yet
  assign rsp_owed = ((state_q == if_pkg::FS_REQ) && instr_gnt_i) ||
                    (((state_q == if_pkg::FS_WAIT) || (state_q == if_pkg::FS_FLUSH)) &&
                     !instr_rvalid_i);

  // ------------------------------
  // next state and strobes
  // ------------------------------
  always_comb begin
    state_d      = state_q;
    load_pc_o    = 1'b0;
    advance_pc_o = 1'b0;
    capture_o    = 1'b0;
    transfer_o   = 1'b0;

    case (state_q)
      // nothing fetched yet, wait for the core to start us
      if_pkg::FS_IDLE: begin
        if (req_i) begin
          load_pc_o = 1'b1;
          state_d   = if_pkg::FS_REQ;
        end
      end

      // request is held until the memory grants it
      if_pkg::FS_REQ: begin
        if (instr_gnt_i) begin
          state_d = if_pkg::FS_WAIT;
        end
      end

      // word arrives, park it in the fetch slot and step the PC
      if_pkg::FS_WAIT: begin
        if (instr_rvalid_i) begin
          capture_o    = 1'b1;
          advance_pc_o = 1'b1;
          state_d      = if_pkg::FS_FULL;
        end
      end

      // stale response after a redirect, swallow it
      if_pkg::FS_FLUSH: begin
        if (instr_rvalid_i) begin
          state_d = if_pkg::FS_REQ;
        end
      end

      // fetch slot occupied, no new request until it moves on
      if_pkg::FS_FULL: begin
        if (id_slot_free_i && !halt_if_i) begin
          transfer_o = 1'b1;
          state_d    = if_pkg::FS_REQ;
        end
      end

      default: begin
        state_d = if_pkg::FS_IDLE;
      end
    endcase

    // redirect wins over everything in any state
    if (pc_set_i) begin
      load_pc_o    = 1'b1;
      advance_pc_o = 1'b0;
      capture_o    = 1'b0;
      // old word must not reach IF/ID
      transfer_o   = 1'b0;
      state_d      = rsp_owed ? if_pkg::FS_FLUSH : if_pkg::FS_REQ;
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------
  assign instr_req_o = (state_q == if_pkg::FS_REQ);

  // busy while the memory port is in use
  assign if_busy_o = (state_q == if_pkg::FS_REQ)  ||
                     (state_q == if_pkg::FS_WAIT) ||
                     (state_q == if_pkg::FS_FLUSH);

endmodule

/* design/if_id_pipe.sv */
`timescale 1ns/1ps

module if_id_pipe (
  input  logic           clk,
  input  logic           rst_n,

  // strobes from the controller
  input  logic           capture_i,
  input  logic           transfer_i,

  // redirect, drops what decode has not taken
  input  logic           flush_i,

  // response word and the PC it was fetched from
  input  if_pkg::instr_t instr_rdata_i,
  input  if_pkg::addr_t  pc_if_i,

  // decode side
  input  logic           id_ready_i,
  output logic           id_slot_free_o,
  output if_pkg::if_id_t if_id_o
);

  // fetch slot, occupancy is tracked by the controller state
  if_pkg::instr_t slot_instr_q;
  if_pkg::addr_t  slot_pc_q;

  // IF/ID register
  logic           id_valid_q;
  if_pkg::instr_t id_instr_q;
  if_pkg::addr_t  id_pc_q;

  // ------------------------------
  // fetch slot
  // ------------------------------
  always_ff @(posedge clk) begin
    if (capture_i) begin
      slot_instr_q <= instr_rdata_i;
      slot_pc_q    <= pc_if_i;
    end
  end

  // ------------------------------
  // IF/ID register
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else if (transfer_i) begin
      id_valid_q <= 1'b1;
    end else if (flush_i) begin
      id_valid_q <= 1'b0;
    end else if (id_valid_q && id_ready_i) begin
      // decode took it and nothing new came in
      id_valid_q <= 1'b0;
    end
  end

  // payload follows the transfer only
  always_ff @(posedge clk) begin
    if (transfer_i) begin
      id_instr_q <= slot_instr_q;
      id_pc_q    <= slot_pc_q;
    end
  end

  // empty, or emptied by decode at this edge
  assign id_slot_free_o = !id_valid_q || id_ready_i;

  assign if_id_o.valid = id_valid_q;
  assign if_id_o.instr = id_instr_q;
  assign if_id_o.pc    = id_pc_q;

endmodule

/* design/if_stage_top.sv */
`timescale 1ns/1ps

module if_stage_top #(
  parameter if_pkg::addr_t DM_HALT_ADDR = 32'h1A11_0800
) (
  input  logic                clk,
  input  logic                rst_n,

  // fetch start and redirect requests
  input  logic                req_i,
  input  logic                pc_set_i,
  input  if_pkg::redirect_t   redirect_i,
  input  if_pkg::pc_sources_t sources_i,

  // instruction memory port
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::instr_t      instr_rdata_i,

  // decode side
  input  logic                id_ready_i,
  input  logic                halt_if_i,
  output if_pkg::if_id_t      if_id_o,
  output if_pkg::addr_t       pc_if_o,
  output logic                if_busy_o
);

  // ------------------------------
  // strobes between the blocks
  // ------------------------------
  logic          load_pc;
  logic          advance_pc;
  logic          capture;
  logic          transfer;
  logic          id_slot_free;
  if_pkg::addr_t pc_if;

  // controller owns the memory handshake
  fetch_ctrl_fsm i_fetch_ctrl_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .halt_if_i      (halt_if_i),
    .id_slot_free_i (id_slot_free),
    .instr_req_o    (instr_req_o),
    .load_pc_o      (load_pc),
    .advance_pc_o   (advance_pc),
    .capture_o      (capture),
    .transfer_o     (transfer),
    .if_busy_o      (if_busy_o)
  );

  // fence.i restarts after the instruction sitting in decode
  fetch_pc_counter #(
    .DM_HALT_ADDR (DM_HALT_ADDR)
  ) i_fetch_pc_counter (
    .clk        (clk),
    .rst_n      (rst_n),
    .load_i     (load_pc),
    .advance_i  (advance_pc),
    .redirect_i (redirect_i),
    .sources_i  (sources_i),
    .pc_id_i    (if_id_o.pc),
    .pc_o       (pc_if)
  );

  // a redirect also empties the IF/ID slot
  if_id_pipe i_if_id_pipe (
    .clk            (clk),
    .rst_n          (rst_n),
    .capture_i      (capture),
    .transfer_i     (transfer),
    .flush_i        (pc_set_i),
    .instr_rdata_i  (instr_rdata_i),
    .pc_if_i        (pc_if),
    .id_ready_i     (id_ready_i),
    .id_slot_free_o (id_slot_free),
    .if_id_o        (if_id_o)
  );

  // the same PC addresses memory and is reported to the core
  assign instr_addr_o = pc_if;
  assign pc_if_o      = pc_if;

endmodule

/* tests/if_stage_asserts.sv */
`timescale 1ns/1ps

module if_stage_asserts (
  input logic           clk,
  input logic           rst_n,
  input logic           pc_set_i,
  input logic           instr_req_i,
  input if_pkg::addr_t  instr_addr_i,
  input logic           instr_gnt_i,
  input logic           instr_rvalid_i,
  input if_pkg::if_id_t if_id_i
);

  // failed assertions, summed up by the testbench
  int unsigned fail_cnt = 0;

  // granted and not answered yet
  logic owed_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owed_q <= 1'b0;
    end else if (instr_req_i && instr_gnt_i) begin
      owed_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      owed_q <= 1'b0;
    end
  end

  // ------------------------------
  // memory port protocol
  // ------------------------------
  a_gnt_with_req: assert property (@(posedge clk) disable iff (!rst_n)
    instr_gnt_i |-> instr_req_i)
    else begin
      fail_cnt++;
      $error("grant while no request is pending");
    end

  // only a redirect may move the address of a waiting request
  a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_i && !instr_gnt_i && !pc_set_i) |=> (instr_req_i && $stable(instr_addr_i)))
    else begin
      fail_cnt++;
      $error("request or address changed before grant");
    end

  a_quiet_in_reset: assert property (@(posedge clk)
    !rst_n |=> (!instr_req_i && !if_id_i.valid))
    else begin
      fail_cnt++;
      $error("request or IF/ID valid high coming out of reset");
    end

  a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    owed_q |-> !instr_req_i)
    else begin
      fail_cnt++;
      $error("new request while a response is still owed");
    end

endmodule

bind if_stage_top if_stage_asserts i_if_stage_asserts (
  .clk            (clk),
  .rst_n          (rst_n),
  .pc_set_i       (pc_set_i),
  .instr_req_i    (instr_req_o),
  .instr_addr_i   (instr_addr_o),
  .instr_gnt_i    (instr_gnt_i),
  .instr_rvalid_i (instr_rvalid_i),
  .if_id_i        (if_id_o)
);

/* tests/tb_if_stage.sv */
`timescale 1ns/1ps

module tb_if_stage;

  localparam if_pkg::addr_t  DM_HALT_ADDR = 32'h1A11_0800;
  localparam if_pkg::addr_t  BOOT_ADDR    = 32'h0000_8000;
  // memory content is the address with this mask applied
  localparam if_pkg::instr_t DATA_XOR     = 32'h5a5a_0000;
  localparam int             N_INSTR      = 400;
  localparam int             MAX_CYCLES   = 20 * N_INSTR;

  logic                clk;
  logic                rst_n;
  logic                req_i;
  logic                pc_set_i;
  if_pkg::redirect_t   redirect_i;
  if_pkg::pc_sources_t sources_i;
  logic                instr_req_o;
  if_pkg::addr_t       instr_addr_o;
  logic                instr_gnt_i;
  logic                instr_rvalid_i;
  if_pkg::instr_t      instr_rdata_i;
  logic                id_ready_i;
  logic                halt_if_i;
  if_pkg::if_id_t      if_id_o;
  if_pkg::addr_t       pc_if_o;
  logic                if_busy_o;

  int            seed;
  int            cycles;
  int            iter;
  int            val_errs;
  int            other_errs;
  int            taken;
  int            redirects;
  int            flushes;
  bit            booted;
  // next PC that decode should take
  if_pkg::addr_t exp_pc;
  // address the next memory request should carry
  if_pkg::addr_t fetch_pc;

  // memory responder state sampled at the falling edge
  logic          req_seen;
  logic          gnt_seen;
  if_pkg::addr_t addr_seen;
  int            gnt_wait;
  int            rsp_wait;
  bit            rsp_pend;
  if_pkg::addr_t rsp_addr;

  if_stage_top #(
    .DM_HALT_ADDR (DM_HALT_ADDR)
  ) i_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .redirect_i     (redirect_i),
    .sources_i      (sources_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .id_ready_i     (id_ready_i),
    .halt_if_i      (halt_if_i),
    .if_id_o        (if_id_o),
    .pc_if_o        (pc_if_o),
    .if_busy_o      (if_busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_addr(input string name, input if_pkg::addr_t got,
                            input if_pkg::addr_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_instr(input string name, input if_pkg::instr_t got,
                             input if_pkg::instr_t exp);
    if (got !== exp) begin
      val_errs++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      val_errs++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic if_pkg::addr_t rand_addr();
    if_pkg::addr_t a;
    a      = $random(seed);
    a[1:0] = 2'b00;
    return a;
  endfunction

  // ------------------------------
  // reference model of the target
  // ------------------------------
  function automatic if_pkg::addr_t expected_target(input if_pkg::redirect_t r,
                                                    input if_pkg::pc_sources_t s,
                                                    input if_pkg::addr_t pc_id);
    if_pkg::addr_t t;
    t = '0;
    if (r.pc_mux == if_pkg::PC_BOOT) t = {s.boot_addr, 1'b0};
    else if (r.pc_mux == if_pkg::PC_JUMP) t = s.jump_target_id;
    else if (r.pc_mux == if_pkg::PC_BRANCH) t = s.jump_target_ex;
    else if (r.pc_mux == if_pkg::PC_MRET) t = s.mepc;
    else if (r.pc_mux == if_pkg::PC_DRET) t = s.depc;
    else if (r.pc_mux == if_pkg::PC_FENCEI) t = pc_id + 32'd4;
    else if (r.pc_mux == if_pkg::PC_EXCEPTION) begin
      // vectored irq puts the line number above the word offset
      if (r.exc_pc_mux == if_pkg::EXC_PC_IRQ) t = {s.trap_base, 1'b0, r.exc_vec, 2'b00};
      else if (r.exc_pc_mux == if_pkg::EXC_PC_DBD) t = DM_HALT_ADDR;
      else t = {s.trap_base, 8'h00};
    end
    t[0] = 1'b0;
    return t;
  endfunction

  // sampled at the falling edge where everything is stable for the next rising edge
  task automatic observe();
    req_seen  = instr_req_o;
    gnt_seen  = instr_gnt_i;
    addr_seen = instr_addr_o;
    if (!booted) begin
      check_flag("instr_req_o", instr_req_o, 1'b0);
      check_flag("if_busy_o", if_busy_o, 1'b0);
    end
    if (instr_req_o) check_flag("if_busy_o", if_busy_o, 1'b1);
    if (if_id_o.valid && !booted) begin
      other_errs++;
      $display("instruction presented to decode before fetch was started at %0t", $time);
    end
    // request goes out at the redirect target or one word past the last grant
    if (booted && instr_req_o) begin
      check_addr("instr_addr_o", instr_addr_o, fetch_pc);
      check_addr("pc_if_o", pc_if_o, fetch_pc);
    end
    if (instr_req_o && instr_gnt_i) fetch_pc = fetch_pc + 32'd4;
    // decode takes the slot at the next edge
    if (if_id_o.valid && id_ready_i) begin
      check_addr("if_id_o.pc", if_id_o.pc, exp_pc);
      check_instr("if_id_o.instr", if_id_o.instr, exp_pc ^ DATA_XOR);
      exp_pc = exp_pc + 32'd4;
      taken++;
    end
    if (req_i && !booted) begin
      exp_pc   = expected_target(redirect_i, sources_i, if_id_o.pc);
      fetch_pc = exp_pc;
      booted   = 1'b1;
    end else if (pc_set_i) begin
      exp_pc   = expected_target(redirect_i, sources_i, if_id_o.pc);
      fetch_pc = exp_pc;
    end
  endtask

  // ------------------------------
  // memory responder
  // ------------------------------
  task automatic drive_memory();
    instr_rvalid_i <= 1'b0;
    // data bus carries garbage outside a response
    if (instr_rvalid_i) instr_rdata_i <= $random(seed);
    if (req_seen && gnt_seen) begin
      instr_gnt_i <= 1'b0;
      rsp_pend    = 1'b1;
      rsp_addr    = addr_seen;
      rsp_wait    = rand_below(3);
      gnt_wait    = rand_below(4);
    end else if (req_seen) begin
      if (gnt_wait == 0) instr_gnt_i <= 1'b1;
      else gnt_wait--;
    end
    if (rsp_pend) begin
      if (rsp_wait == 0) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= rsp_addr ^ DATA_XOR;
        rsp_pend = 1'b0;
      end else begin
        rsp_wait--;
      end
    end
  endtask

  task automatic issue_redirect();
    if_pkg::redirect_t   r;
    if_pkg::pc_sources_t s;
    s = sources_i;
    case (rand_below(6))
      0: r.pc_mux = if_pkg::PC_JUMP;
      1: r.pc_mux = if_pkg::PC_BRANCH;
      2: r.pc_mux = if_pkg::PC_EXCEPTION;
      3: r.pc_mux = if_pkg::PC_MRET;
      4: r.pc_mux = if_pkg::PC_DRET;
      default: r.pc_mux = if_pkg::PC_FENCEI;
    endcase
    case (rand_below(3))
      0: r.exc_pc_mux = if_pkg::EXC_PC_EXCEPTION;
      1: r.exc_pc_mux = if_pkg::EXC_PC_IRQ;
      default: r.exc_pc_mux = if_pkg::EXC_PC_DBD;
    endcase
    r.exc_vec        = $random(seed);
    s.trap_base      = $random(seed);
    s.jump_target_id = rand_addr();
    s.jump_target_ex = rand_addr();
    s.mepc           = rand_addr();
    s.depc           = rand_addr();
    redirect_i <= r;
    sources_i  <= s;
    pc_set_i   <= 1'b1;
    redirects++;
    if (rsp_pend) flushes++;
  endtask

  // decode back-pressure, boot start and redirects
  task automatic drive_core();
    int unsigned chance;
    chance = rsp_pend ? 4 : 1;
    id_ready_i <= (rand_below(4) != 0);
    halt_if_i  <= (rand_below(8) == 0);
    pc_set_i   <= 1'b0;
    if (iter == 4) req_i <= 1'b1;
    // first three boot words run without a redirect
    if (booted && taken >= 3 && rand_below(16) < chance) issue_redirect();
  endtask

  initial begin
    seed           = 32'h0a5c_ddf8;
    rst_n          = 1'b0;
    req_i          = 1'b0;
    pc_set_i       = 1'b0;
    redirect_i     = '0;
    sources_i      = '0;
    sources_i.boot_addr = BOOT_ADDR[31:1];
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    id_ready_i     = 1'b0;
    halt_if_i      = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    while (taken < N_INSTR) begin
      @(negedge clk);
      observe();
      @(posedge clk);
      drive_memory();
      drive_core();
      iter++;
    end
    $display("errors: %0d value, %0d other, %0d assertion; taken %0d, redirects %0d, flushes %0d",
             val_errs, other_errs, i_dut.i_if_stage_asserts.fail_cnt, taken, redirects,
             flushes);
    if (val_errs + other_errs + i_dut.i_if_stage_asserts.fail_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // stop a run that no longer makes progress
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, only %0d of %0d instructions taken",
               cycles, taken, N_INSTR);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

/* list.f */
common/if_pkg.sv
fetch/fetch_pc_counter.sv
fetch/fetch_ctrl_fsm.sv
design/if_id_pipe.sv
design/if_stage_top.sv
tests/if_stage_asserts.sv
tests/tb_if_stage.sv
